// File: tests/fragmentGolden.txt
// depthTestEnable depthFunc alphaFunc alphaRef srcFactor dstFactor index depth color
// dstColor dstDepth expColorWriteEnable expDepthWriteEnable expColorOut (all hex)
1 0 7 0 1 0 0001 0100 F8C4 1234 0200 0 0 0000
1 1 7 0 1 0 0002 0100 F8C4 1234 0200 1 1 F8C4
1 1 7 0 1 0 0003 0300 3C5A 1234 0200 0 0 0000
1 2 7 0 1 0 0004 0200 3C5A 1234 0200 1 1 3C5A
1 3 7 0 1 0 0005 0201 7E19 1234 0200 0 0 0000
1 3 7 0 1 0 000A 0200 9999 1234 0200 1 1 9999
1 4 7 0 1 0 0006 0201 7E19 1234 0200 1 1 7E19
1 5 7 0 1 0 0007 0200 A0B1 1234 0200 0 0 0000
1 6 7 0 1 0 0008 0200 A0B1 1234 0200 1 1 A0B1
1 7 7 0 1 0 0009 FFFF 2468 1234 0000 1 1 2468
0 0 7 0 1 0 000B 0500 5A5A 1111 0100 1 0 5A5A
0 0 7 0 1 0 000C 0050 C3C3 1111 0100 1 0 C3C3
1 7 1 8 1 0 000D 0100 1234 1111 0100 1 1 1234
1 7 1 8 1 0 000E 0100 1239 1111 0100 0 0 0000
1 7 6 8 1 0 000F 0100 4448 1111 0100 1 1 4448
1 7 2 5 1 0 0010 0100 7776 1111 0100 0 0 0000
1 7 0 5 1 0 0011 0100 7775 1111 0100 0 0 0000
1 1 4 3 1 0 0012 0010 8882 1111 0100 0 0 0000
1 7 7 0 6 7 0013 0100 F008 0F0F 0100 1 1 870B
1 7 7 0 4 0 0014 0100 8F4C F82A 0100 1 1 8818
1 7 7 0 1 1 0015 0100 8421 4218 0100 1 1 C639
1 7 7 0 1 1 0016 0100 FFF8 1F89 0100 1 1 FFFF

// File: files.f
rtl/fragmentPkg.sv
rtl/fragmentIf.sv
rtl/fragmentFetch.sv
rtl/fragmentTest.sv
rtl/colorBlender.sv
rtl/framebufferWriter.sv
rtl/fragmentPipeline.sv
tests/fragmentPipelineTb.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing
TOP = fragmentPipelineTb
FILELIST = files.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: tests/fragmentPipelineTb.sv
////////////////////////////////////////
// Fragment back end testbench with clock, reset, framebuffer model,
// golden-file driver, checker and timeout
////////////////////////////////////////
`timescale 1ns/1ns

module fragmentPipelineTb;

    localparam int MAX_VECTORS = 64;
    localparam int FIELDS = 14;
    localparam int LATENCY = 6;
    localparam int DRAIN_CYCLES = 8;

    logic clk;
    logic arstN;
    logic fragValid;
    fragmentPkg::fbIndexT fragIndex;
    fragmentPkg::depthT fragDepth;
    fragmentPkg::colorT fragColor;
    fragmentPkg::fbIndexT readIndex;
    fragmentPkg::colorT colorIn;
    fragmentPkg::depthT depthIn;
    fragmentPkg::fbIndexT writeIndex;
    fragmentPkg::colorT colorOut;
    fragmentPkg::depthT depthOut;
    logic colorWriteEnable;
    logic depthWriteEnable;
    logic depthTestEnable;
    fragmentPkg::compareFuncT depthFunc;
    fragmentPkg::compareFuncT alphaFunc;
    fragmentPkg::channelT alphaRef;
    fragmentPkg::blendFactorT srcFactor;
    fragmentPkg::blendFactorT dstFactor;

    // Framebuffer memories
    logic [15:0] colorMem [0 : (1 << fragmentPkg::FB_INDEX_WIDTH) - 1];
    logic [15:0] depthMem [0 : (1 << fragmentPkg::FB_INDEX_WIDTH) - 1];

    // Golden vectors with the columns of the data file
    logic [15:0] vectors [MAX_VECTORS][FIELDS];
    int vectorCount;
    int configChanges;
    int cycleLimit;

    // Pending checks as due negedge count and vector number
    int dueQ [$];
    int vectorQ [$];

    int cycleCount;
    int valueErrors;
    int protocolErrors;
    logic [15:0] lfsrState;

    fragmentPipeline UUT
    (
        .clk(clk),
        .arstN(arstN),
        .fragValid(fragValid),
        .fragIndex(fragIndex),
        .fragDepth(fragDepth),
        .fragColor(fragColor),
        .readIndex(readIndex),
        .colorIn(colorIn),
        .depthIn(depthIn),
        .writeIndex(writeIndex),
        .colorOut(colorOut),
        .depthOut(depthOut),
        .colorWriteEnable(colorWriteEnable),
        .depthWriteEnable(depthWriteEnable),
        .depthTestEnable(depthTestEnable),
        .depthFunc(depthFunc),
        .alphaFunc(alphaFunc),
        .alphaRef(alphaRef),
        .srcFactor(srcFactor),
        .dstFactor(dstFactor)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        lfsrStep = {state[14:0], feedback};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            valueErrors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic loadVectors();
        int fd;
        int count;
        string line;
        logic [15:0] f [FIELDS];
        vectorCount = 0;
        fd = $fopen("tests/fragmentGolden.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the golden vector file");
        end
        else
        begin
            while (!$feof(fd) && vectorCount < MAX_VECTORS)
            begin
                line = "";
                void'($fgets(line, fd));
                count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                if (count == FIELDS)
                begin
                    for (int k = 0; k < FIELDS; k++)
                    begin
                        vectors[vectorCount][k] = f[k];
                    end
                    vectorCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Columns 0 to 5 hold the configuration
    function automatic logic configDiffers(input int i);
        configDiffers = 1'b0;
        for (int k = 0; k < 6; k++)
        begin
            if (vectors[i][k] !== vectors[i - 1][k])
            begin
                configDiffers = 1'b1;
            end
        end
    endfunction

    ////////////////////////////////////////
    // Framebuffer model with registered read
    ////////////////////////////////////////
    always @(posedge clk)
    begin
        colorIn <= colorMem[readIndex];
        depthIn <= depthMem[readIndex];
        if (colorWriteEnable)
        begin
            colorMem[writeIndex] <= colorOut;
        end
        if (depthWriteEnable)
        begin
            depthMem[writeIndex] <= depthOut;
        end
    end

    ////////////////////////////////////////
    // Checker and timeout on the falling edge
    ////////////////////////////////////////
    always @(negedge clk)
    begin
        int v;
        cycleCount++;
        if (!arstN)
        begin
            checkValue("colorWriteEnable", colorWriteEnable, 0);
            checkValue("depthWriteEnable", depthWriteEnable, 0);
        end
        else if (dueQ.size() > 0 && dueQ[0] == cycleCount)
        begin
            v = vectorQ[0];
            void'(dueQ.pop_front());
            void'(vectorQ.pop_front());
            if (vectors[v][11][0] && !colorWriteEnable)
            begin
                protocolErrors++;
                $display("Missing write strobe for vector %0d", v);
            end
            else
            begin
                checkValue("colorWriteEnable", colorWriteEnable, vectors[v][11]);
            end
            checkValue("depthWriteEnable", depthWriteEnable, vectors[v][12]);
            if (vectors[v][11][0])
            begin
                checkValue("writeIndex", writeIndex, vectors[v][6]);
                checkValue("colorOut", colorOut, vectors[v][13]);
                checkValue("depthOut", depthOut, vectors[v][7]);
            end
        end
        else if (colorWriteEnable || depthWriteEnable)
        begin
            protocolErrors++;
            $display("Write strobe at cycle %0d with no fragment expected", cycleCount);
        end
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
        begin
            $display("Timeout, run did not finish within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Driver
    ////////////////////////////////////////
    initial
    begin
        int gap;
        arstN = 1'b0;
        fragValid = 1'b0;
        fragIndex = '0;
        fragDepth = '0;
        fragColor = '0;
        colorIn = '0;
        depthIn = '0;
        depthTestEnable = 1'b0;
        depthFunc = fragmentPkg::ALWAYS;
        alphaFunc = fragmentPkg::ALWAYS;
        alphaRef = '0;
        srcFactor = fragmentPkg::ONE;
        dstFactor = fragmentPkg::ZERO;
        cycleCount = 0;
        cycleLimit = 0;
        valueErrors = 0;
        protocolErrors = 0;
        lfsrState = 16'd12;
        for (int a = 0; a < (1 << fragmentPkg::FB_INDEX_WIDTH); a++)
        begin
            colorMem[a] = 16'(a) ^ 16'hA5A5;
            depthMem[a] = ~16'(a);
        end

        loadVectors();
        if (vectorCount == 0)
        begin
            $display("No vectors could be read from the golden vector file");
            $display("TEST RESULT: FAIL");
        end
        else
        begin
            configChanges = 0;
            for (int i = 1; i < vectorCount; i++)
            begin
                if (configDiffers(i))
                begin
                    configChanges++;
                end
            end
            cycleLimit = vectorCount * 4 + 16 + 20 + configChanges * DRAIN_CYCLES;

            repeat (16) @(posedge clk);
            arstN <= 1'b1;

            for (int i = 0; i < vectorCount; i++)
            begin
                // Let the pipeline drain before the configuration moves
                if (i > 0 && configDiffers(i))
                begin
                    repeat (DRAIN_CYCLES)
                    begin
                        @(posedge clk);
                        fragValid <= 1'b0;
                    end
                end
                @(posedge clk);
                colorMem[vectors[i][6]] = vectors[i][9];
                depthMem[vectors[i][6]] = vectors[i][10];
                depthTestEnable <= vectors[i][0][0];
                depthFunc <= fragmentPkg::compareFuncT'(vectors[i][1][2:0]);
                alphaFunc <= fragmentPkg::compareFuncT'(vectors[i][2][2:0]);
                alphaRef <= vectors[i][3][3:0];
                srcFactor <= fragmentPkg::blendFactorT'(vectors[i][4][3:0]);
                dstFactor <= fragmentPkg::blendFactorT'(vectors[i][5][3:0]);
                fragValid <= 1'b1;
                fragIndex <= vectors[i][6][fragmentPkg::FB_INDEX_WIDTH - 1 : 0];
                fragDepth <= vectors[i][7];
                fragColor <= vectors[i][8];
                // Accepted on the next edge, strobe seen on the falling edge after it
                dueQ.push_back(cycleCount + LATENCY + 2);
                vectorQ.push_back(i);
                lfsrState = lfsrStep(lfsrState);
                gap = lfsrState[0];
                lfsrState = lfsrStep(lfsrState);
                gap = gap * 2 + lfsrState[0];
                repeat (gap)
                begin
                    @(posedge clk);
                    fragValid <= 1'b0;
                end
            end
            @(posedge clk);
            fragValid <= 1'b0;

            while (dueQ.size() > 0)
            begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);

            $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
            if (valueErrors == 0 && protocolErrors == 0)
            begin
                $display("TEST RESULT: PASS");
            end
            else
            begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

// File: rtl/fragmentPipeline.sv
////////////////////////////////////////
// Fragment back end top level
////////////////////////////////////////
`timescale 1ns/1ns

module fragmentPipeline
(
    input  logic                     clk,
    input  logic                     arstN,

    // Fragment input
    input  logic                     fragValid,
    input  fragmentPkg::fbIndexT     fragIndex,
    input  fragmentPkg::depthT       fragDepth,
    input  fragmentPkg::colorT       fragColor,

    // Framebuffer read, one cycle latency
    output fragmentPkg::fbIndexT     readIndex,
    input  fragmentPkg::colorT       colorIn,
    input  fragmentPkg::depthT       depthIn,

    // Framebuffer write
    output fragmentPkg::fbIndexT     writeIndex,
    output fragmentPkg::colorT       colorOut,
    output fragmentPkg::depthT       depthOut,
    output logic                     colorWriteEnable,
    output logic                     depthWriteEnable,

    // Configuration, stable while fragments are in flight
    input  logic                     depthTestEnable,
    input  fragmentPkg::compareFuncT depthFunc,
    input  fragmentPkg::compareFuncT alphaFunc,
    input  fragmentPkg::channelT     alphaRef,
    input  fragmentPkg::blendFactorT srcFactor,
    input  fragmentPkg::blendFactorT dstFactor
);

    fragmentIf fetchToTest();
    fragmentIf testToBlend();
    fragmentIf blendToWrite();

    fragmentFetch fetch
    (
        .clk(clk),
        .arstN(arstN),
        .fragValid(fragValid),
        .fragIndex(fragIndex),
        .fragDepth(fragDepth),
        .fragColor(fragColor),
        .readIndex(readIndex),
        .colorIn(colorIn),
        .depthIn(depthIn),
        .out(fetchToTest.src)
    );

    fragmentTest test
    (
        .clk(clk),
        .arstN(arstN),
        .depthTestEnable(depthTestEnable),
        .depthFunc(depthFunc),
        .alphaFunc(alphaFunc),
        .alphaRef(alphaRef),
        .in(fetchToTest.snk),
        .out(testToBlend.src)
    );

    colorBlender blender
    (
        .clk(clk),
        .arstN(arstN),
        .srcFactor(srcFactor),
        .dstFactor(dstFactor),
        .in(testToBlend.snk),
        .out(blendToWrite.src)
    );

    framebufferWriter writer
    (
        .clk(clk),
        .arstN(arstN),
        .depthTestEnable(depthTestEnable),
        .in(blendToWrite.snk),
        .writeIndex(writeIndex),
        .colorOut(colorOut),
        .depthOut(depthOut),
        .colorWriteEnable(colorWriteEnable),
        .depthWriteEnable(depthWriteEnable)
    );

endmodule

// File: rtl/framebufferWriter.sv
////////////////////////////////////////
// Framebuffer write port registers
////////////////////////////////////////
`timescale 1ns/1ns

module framebufferWriter
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 depthTestEnable,
    fragmentIf.snk               in,
    output fragmentPkg::fbIndexT writeIndex,
    output fragmentPkg::colorT   colorOut,
    output fragmentPkg::depthT   depthOut,
    output logic                 colorWriteEnable,
    output logic                 depthWriteEnable
);

    // Strobes last one cycle per fragment
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            colorWriteEnable <= 1'b0;
            depthWriteEnable <= 1'b0;
        end
        else
        begin
            colorWriteEnable <= in.valid && in.writeAllowed;
            // Depth is only stored when the depth test is on
            depthWriteEnable <= in.valid && in.writeAllowed && depthTestEnable;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in.valid)
        begin
            writeIndex <= in.fbIndex;
            colorOut <= in.color;
            depthOut <= in.depth;
        end
    end

endmodule

// File: rtl/colorBlender.sv
////////////////////////////////////////
// Two-stage blend of fragment color with stored color
////////////////////////////////////////
`timescale 1ns/1ns

module colorBlender
(
    input  logic                     clk,
    input  logic                     arstN,
    input  fragmentPkg::blendFactorT srcFactor,
    input  fragmentPkg::blendFactorT dstFactor,
    fragmentIf.snk                   in,
    fragmentIf.src                   out
);

    // Factor for one channel, both source and destination factors use it
    function automatic fragmentPkg::channelT selectFactor
    (
        fragmentPkg::blendFactorT factor,
        fragmentPkg::channelT srcChannel,
        fragmentPkg::channelT srcAlpha,
        fragmentPkg::channelT dstChannel,
        fragmentPkg::channelT dstAlpha
    );
        case (factor)
            fragmentPkg::ZERO:
                selectFactor = '0;
            fragmentPkg::ONE:
                selectFactor = fragmentPkg::CHANNEL_MAX;
            fragmentPkg::SRC_COLOR:
                selectFactor = srcChannel;
            fragmentPkg::ONE_MINUS_SRC_COLOR:
                selectFactor = fragmentPkg::CHANNEL_MAX - srcChannel;
            fragmentPkg::DST_COLOR:
                selectFactor = dstChannel;
            fragmentPkg::ONE_MINUS_DST_COLOR:
                selectFactor = fragmentPkg::CHANNEL_MAX - dstChannel;
            fragmentPkg::SRC_ALPHA:
                selectFactor = srcAlpha;
            fragmentPkg::ONE_MINUS_SRC_ALPHA:
                selectFactor = fragmentPkg::CHANNEL_MAX - srcAlpha;
            fragmentPkg::DST_ALPHA:
                selectFactor = dstAlpha;
            fragmentPkg::ONE_MINUS_DST_ALPHA:
                selectFactor = fragmentPkg::CHANNEL_MAX - dstAlpha;
            default:
                selectFactor = '0;
        endcase
    endfunction

    localparam int W = fragmentPkg::CHANNEL_WIDTH;

    fragmentPkg::channelT srcAlpha;
    fragmentPkg::channelT dstAlpha;

    // Products stage, index 3 is R and index 0 is A
    logic prodValid;
    fragmentPkg::fbIndexT prodIndex;
    fragmentPkg::depthT prodDepth;
    fragmentPkg::colorT prodDstColor;
    fragmentPkg::depthT prodDstDepth;
    logic prodWriteAllowed;
    fragmentPkg::productT srcProduct [4];
    fragmentPkg::productT dstProduct [4];

    assign srcAlpha = in.color[W - 1 : 0];
    assign dstAlpha = in.dstColor[W - 1 : 0];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            prodValid <= 1'b0;
            out.valid <= 1'b0;
        end
        else
        begin
            prodValid <= in.valid;
            out.valid <= prodValid;
        end
    end

    ////////////////////////////////////////
    // Stage one, factor select and multiply
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (in.valid)
        begin
            for (int i = 0; i < 4; i++)
            begin
                srcProduct[i] <= in.color[i * W +: W]
                    * selectFactor(srcFactor, in.color[i * W +: W], srcAlpha,
                                   in.dstColor[i * W +: W], dstAlpha);
                dstProduct[i] <= in.dstColor[i * W +: W]
                    * selectFactor(dstFactor, in.color[i * W +: W], srcAlpha,
                                   in.dstColor[i * W +: W], dstAlpha);
            end
            prodIndex <= in.fbIndex;
            prodDepth <= in.depth;
            prodDstColor <= in.dstColor;
            prodDstDepth <= in.dstDepth;
            prodWriteAllowed <= in.writeAllowed;
        end
    end

    ////////////////////////////////////////
    // Stage two, round and saturate
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin : sumStage
        logic [2 * W : 0] sum;
        if (prodValid)
        begin
            for (int i = 0; i < 4; i++)
            begin
                // Adding 15 before the shift approximates division by 15
                sum = {1'b0, srcProduct[i]} + {1'b0, dstProduct[i]}
                      + (2 * W + 1)'(fragmentPkg::CHANNEL_MAX);
                out.color[i * W +: W] <= sum[2 * W] ? fragmentPkg::CHANNEL_MAX
                                                    : sum[2 * W - 1 : W];
            end
            out.fbIndex <= prodIndex;
            out.depth <= prodDepth;
            out.dstColor <= prodDstColor;
            out.dstDepth <= prodDstDepth;
            out.writeAllowed <= prodWriteAllowed;
        end
    end

endmodule

// File: rtl/fragmentTest.sv
////////////////////////////////////////
// Depth test and alpha test
////////////////////////////////////////
`timescale 1ns/1ns

module fragmentTest
(
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     depthTestEnable,
    input  fragmentPkg::compareFuncT depthFunc,
    input  fragmentPkg::compareFuncT alphaFunc,
    input  fragmentPkg::channelT     alphaRef,
    fragmentIf.snk                   in,
    fragmentIf.src                   out
);

    // Result of one compare function from the less and equal flags
    function automatic logic comparePassed
    (
        fragmentPkg::compareFuncT func,
        logic less,
        logic equal
    );
        logic greater;
        greater = !less && !equal;
        case (func)
            fragmentPkg::NEVER:    comparePassed = 1'b0;
            fragmentPkg::LESS:     comparePassed = less;
            fragmentPkg::EQUAL:    comparePassed = equal;
            fragmentPkg::LEQUAL:   comparePassed = less || equal;
            fragmentPkg::GREATER:  comparePassed = greater;
            fragmentPkg::NOTEQUAL: comparePassed = !equal;
            fragmentPkg::GEQUAL:   comparePassed = greater || equal;
            fragmentPkg::ALWAYS:   comparePassed = 1'b1;
        endcase
    endfunction

    fragmentPkg::channelT fragAlpha;
    logic depthPassed;
    logic alphaPassed;

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    // Alpha comes straight from the fragment color
    assign fragAlpha = in.color[fragmentPkg::CHANNEL_WIDTH - 1 : 0];

    assign depthPassed = comparePassed(depthFunc,
                                       in.depth < in.dstDepth,
                                       in.depth == in.dstDepth);

    assign alphaPassed = comparePassed(alphaFunc,
                                       fragAlpha < alphaRef,
                                       fragAlpha == alphaRef);

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            out.valid <= 1'b0;
        end
        else
        begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in.valid)
        begin
            out.fbIndex <= in.fbIndex;
            out.depth <= in.depth;
            out.color <= in.color;
            out.dstColor <= in.dstColor;
            out.dstDepth <= in.dstDepth;
            // A disabled depth test lets every fragment through
            out.writeAllowed <= in.writeAllowed
                                && (depthPassed || !depthTestEnable)
                                && alphaPassed;
        end
    end

endmodule

// File: rtl/fragmentFetch.sv
////////////////////////////////////////
// Fragment input register and framebuffer read
////////////////////////////////////////
`timescale 1ns/1ns

module fragmentFetch
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 fragValid,
    input  fragmentPkg::fbIndexT fragIndex,
    input  fragmentPkg::depthT   fragDepth,
    input  fragmentPkg::colorT   fragColor,
    output fragmentPkg::fbIndexT readIndex,
    input  fragmentPkg::colorT   colorIn,
    input  fragmentPkg::depthT   depthIn,
    fragmentIf.src               out
);

    // Accepted fragment, its index addresses both memories
    logic acceptValid;
    fragmentPkg::depthT acceptDepth;
    fragmentPkg::colorT acceptColor;

    // Held while the memories answer
    logic waitValid;
    fragmentPkg::fbIndexT waitIndex;
    fragmentPkg::depthT waitDepth;
    fragmentPkg::colorT waitColor;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            acceptValid <= 1'b0;
            waitValid <= 1'b0;
            out.valid <= 1'b0;
        end
        else
        begin
            acceptValid <= fragValid;
            waitValid <= acceptValid;
            out.valid <= waitValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fragValid)
        begin
            readIndex <= fragIndex;
            acceptDepth <= fragDepth;
            acceptColor <= fragColor;
        end
        if (acceptValid)
        begin
            waitIndex <= readIndex;
            waitDepth <= acceptDepth;
            waitColor <= acceptColor;
        end
        // Read data is present one edge after readIndex moved
        if (waitValid)
        begin
            out.fbIndex <= waitIndex;
            out.depth <= waitDepth;
            out.color <= waitColor;
            out.dstColor <= colorIn;
            out.dstDepth <= depthIn;
        end
    end

    // Only the test stage may deny the write
    assign out.writeAllowed = 1'b1;

endmodule

// File: rtl/fragmentIf.sv
////////////////////////////////////////
// Fragment bundle between pipeline stages
////////////////////////////////////////
`timescale 1ns/1ns

interface fragmentIf;

    logic valid;
    fragmentPkg::fbIndexT fbIndex;
    fragmentPkg::depthT depth;
    // Source color of the fragment, replaced by the blend result
    fragmentPkg::colorT color;
    // Pixel already stored at fbIndex
    fragmentPkg::colorT dstColor;
    fragmentPkg::depthT dstDepth;
    logic writeAllowed;

    modport src
    (
        output valid, fbIndex, depth, color, dstColor, dstDepth, writeAllowed
    );

    modport snk
    (
        input valid, fbIndex, depth, color, dstColor, dstDepth, writeAllowed
    );

endinterface

// File: rtl/fragmentPkg.sv
////////////////////////////////////////
// Shared widths, pixel types and the compare and blend encodings
// of the fragment back end
////////////////////////////////////////
package fragmentPkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int FB_INDEX_WIDTH = 14;
    localparam int CHANNEL_WIDTH = 4;

    ////////////////////////////////////////
    // Pixel types
    ////////////////////////////////////////
    typedef logic [FB_INDEX_WIDTH - 1 : 0] fbIndexT;
    typedef logic [15:0] depthT;

    // RGBA4444, R in the top nibble and A in the bottom nibble
    typedef logic [4 * CHANNEL_WIDTH - 1 : 0] colorT;

    typedef logic [CHANNEL_WIDTH - 1 : 0] channelT;
    typedef logic [2 * CHANNEL_WIDTH - 1 : 0] productT;

    // Full intensity, stands for 1.0 in the channel arithmetic
    localparam channelT CHANNEL_MAX = 15;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////
    // Shared by the depth test and the alpha test
    typedef enum logic [2:0]
    {
        NEVER,
        LESS,
        EQUAL,
        LEQUAL,
        GREATER,
        NOTEQUAL,
        GEQUAL,
        ALWAYS
    } compareFuncT;

    // Codes 10 to 15 are unused
    typedef enum logic [3:0]
    {
        ZERO,
        ONE,
        SRC_COLOR,
        ONE_MINUS_SRC_COLOR,
        DST_COLOR,
        ONE_MINUS_DST_COLOR,
        SRC_ALPHA,
        ONE_MINUS_SRC_ALPHA,
        DST_ALPHA,
        ONE_MINUS_DST_ALPHA
    } blendFactorT;

endpackage
